/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_hpdc_l15_adapter
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard source/*.sv source/*.svh tests/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* source/hpdc_l15_adapter.sv */
// ------------------------------------------------
// HPDC to L1.5 adapter top level
// Request encoder, thread id control and return
// decoder between the cache and the L1.5
// ------------------------------------------------
`timescale 1ns/1ps
`include "l15_adapter_macros.svh"

module hpdc_l15_adapter #(
    parameter bit SWAP_ENDIAN = 1'b1
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          req_valid_i,
    input  logic [`L15A_PID_W-1:0]        req_pid_i,
    input  l15_adapter_pkg::mem_req_t     req_i,
    input  l15_adapter_pkg::mem_wdata_t   req_data_i,
    output logic                          req_ready_o,
    input  logic                          resp_ready_i,
    output logic                          resp_valid_o,
    output logic [`L15A_PID_W-1:0]        resp_pid_o,
    output l15_adapter_pkg::mem_resp_t    resp_o,
    output l15_adapter_pkg::l15_req_t     l15_req_o,
    input  l15_adapter_pkg::l15_rtrn_t    l15_rtrn_i
);

    l15_adapter_pkg::l15_rqtype_e rqtype;
    logic                         nc;
    logic [2:0]                   size;
    logic [`L15A_ADDR_W-1:0]      address;
    logic [`L15A_DATA_W-1:0]      data;
    logic [`L15A_BE_W-1:0]        be;
    logic                         l15_val;
    logic                         req_ack;
    logic [`L15A_TID_W-1:0]       l15_tid;
    logic [`L15A_TID_W-1:0]       lookup_tid;
    logic [`L15A_MEM_ID_W-1:0]    lookup_id;
    logic [`L15A_PID_W-1:0]       lookup_pid;

    l15_req_encoder #(.SWAP_ENDIAN(SWAP_ENDIAN)) i_req_encoder (
        .req_i      (req_i),
        .req_pid_i  (req_pid_i),
        .req_data_i (req_data_i),
        .rqtype_o   (rqtype),
        .nc_o       (nc),
        .size_o     (size),
        .address_o  (address),
        .data_o     (data),
        .be_o       (be)
    );

    l15_thread_ctrl i_thread_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (req_valid_i),
        .req_pid_i    (req_pid_i),
        .req_id_i     (req_i.id),
        .header_ack_i (l15_rtrn_i.header_ack),
        .ack_i        (l15_rtrn_i.ack),
        .rtrn_val_i   (l15_rtrn_i.val),
        .rtrn_tid_i   (l15_rtrn_i.threadid),
        .resp_ready_i (resp_ready_i),
        .l15_val_o    (l15_val),
        .l15_tid_o    (l15_tid),
        .req_ready_o  (req_ready_o),
        .lookup_tid_i (lookup_tid),
        .lookup_id_o  (lookup_id),
        .lookup_pid_o (lookup_pid)
    );

    l15_resp_decoder #(.SWAP_ENDIAN(SWAP_ENDIAN)) i_resp_decoder (
        .l15_rtrn_i   (l15_rtrn_i),
        .resp_ready_i (resp_ready_i),
        .lookup_id_i  (lookup_id),
        .lookup_pid_i (lookup_pid),
        .lookup_tid_o (lookup_tid),
        .resp_valid_o (resp_valid_o),
        .resp_pid_o   (resp_pid_o),
        .resp_o       (resp_o),
        .req_ack_o    (req_ack)
    );

    // L1.5 request word
    assign l15_req_o = '{
        val:      l15_val,
        req_ack:  req_ack,
        rqtype:   rqtype,
        nc:       nc,
        size:     size,
        threadid: l15_tid,
        address:  address,
        data:     data,
        be:       be
    };

endmodule

/* source/l15_adapter_macros.svh */
// ------------------------------------------------
// HPDC to L1.5 adapter
// Widths, thread id count and cache port numbers
// ------------------------------------------------
`ifndef L15_ADAPTER_MACROS_SVH
`define L15_ADAPTER_MACROS_SVH

// Data path widths
`define L15A_ADDR_W     40
`define L15A_DATA_W     64
`define L15A_BE_W       8

// Request tags
`define L15A_MEM_ID_W   4
`define L15A_PID_W      2
`define L15A_TID_W      2
`define L15A_NUM_THIDS  4  // One per L1.5 thread id

// Cache ports feeding the adapter
`define L15A_PORT_RD      2'd0
`define L15A_PORT_WBUF    2'd1
`define L15A_PORT_UNC_RD  2'd2
`define L15A_PORT_UNC_WR  2'd3

`endif

/* source/l15_adapter_pkg.sv */
// ------------------------------------------------
// HPDC to L1.5 adapter types
// Cache memory port and L1.5 request/return words
// ------------------------------------------------
`include "l15_adapter_macros.svh"

package l15_adapter_pkg;

    // Cache memory command
    typedef enum logic [1:0] {
        MEM_READ  = 2'b00,
        MEM_WRITE = 2'b01
    } mem_cmd_e;

    // L1.5 request and return codes
    typedef enum logic [4:0] {
        L15_LOAD_RQ  = 5'b00000,
        L15_STORE_RQ = 5'b00001
    } l15_rqtype_e;

    typedef enum logic [3:0] {
        L15_LOAD_RET = 4'b0000,
        L15_ST_ACK   = 4'b0100,
        L15_ERR_RET  = 4'b1100
    } l15_rettype_e;

    typedef struct packed {
        logic [`L15A_ADDR_W-1:0]   addr;
        logic [2:0]                size;      // Log2 of the byte count
        logic [`L15A_MEM_ID_W-1:0] id;
        mem_cmd_e                  command;
        logic                      cacheable;
    } mem_req_t;

    typedef struct packed {
        logic [`L15A_DATA_W-1:0] data;
        logic [`L15A_BE_W-1:0]   be;
    } mem_wdata_t;

    typedef struct packed {
        logic [`L15A_MEM_ID_W-1:0] id;
        logic                      error;
        logic [`L15A_DATA_W-1:0]   data;
    } mem_resp_t;

    typedef struct packed {
        logic                    val;
        logic                    req_ack;   // Return accepted
        l15_rqtype_e             rqtype;
        logic                    nc;
        logic [2:0]              size;
        logic [`L15A_TID_W-1:0]  threadid;
        logic [`L15A_ADDR_W-1:0] address;
        logic [`L15A_DATA_W-1:0] data;      // Big endian
        logic [`L15A_BE_W-1:0]   be;
    } l15_req_t;

    typedef struct packed {
        logic                    val;
        logic                    header_ack;
        logic                    ack;
        l15_rettype_e            returntype;
        logic [`L15A_TID_W-1:0]  threadid;
        logic [`L15A_DATA_W-1:0] data;
    } l15_rtrn_t;

endpackage

/* source/l15_req_encoder.sv */
// ------------------------------------------------
// L1.5 request encoder
// Maps a cache memory request onto L1.5 request
// fields, aligning stores from their byte mask
// ------------------------------------------------
`timescale 1ns/1ps
`include "l15_adapter_macros.svh"

module l15_req_encoder #(
    parameter bit SWAP_ENDIAN = 1'b1
) (
    input  l15_adapter_pkg::mem_req_t     req_i,
    input  logic [`L15A_PID_W-1:0]        req_pid_i,
    input  l15_adapter_pkg::mem_wdata_t   req_data_i,
    output l15_adapter_pkg::l15_rqtype_e  rqtype_o,
    output logic                          nc_o,
    output logic [2:0]                    size_o,
    output logic [`L15A_ADDR_W-1:0]       address_o,
    output logic [`L15A_DATA_W-1:0]       data_o,
    output logic [`L15A_BE_W-1:0]         be_o
);

    logic                    is_wbuf_st;
    logic                    is_unc_st;
    logic [3:0]              be_cnt;
    logic [2:0]              hi_pos;    // Highest enabled byte
    logic [1:0]              wt_size;
    logic [2:0]              wt_off;
    logic [`L15A_ADDR_W-1:0] wt_addr;
    logic [`L15A_DATA_W-1:0] rep_data;
    logic [`L15A_DATA_W-1:0] st_data;
    logic [`L15A_DATA_W-1:0] st_data_swap;
    logic [`L15A_BE_W-1:0]   be_swap;

    assign is_wbuf_st = (req_pid_i == `L15A_PORT_WBUF) &&
                        (req_i.command == l15_adapter_pkg::MEM_WRITE);
    assign is_unc_st  = (req_pid_i == `L15A_PORT_UNC_WR) &&
                        (req_i.command == l15_adapter_pkg::MEM_WRITE);

    assign be_cnt = 4'($countones(req_data_i.be));

    always_comb begin : hi_pos_comb
        hi_pos = '0;
        for (int i = 0; i < `L15A_BE_W; i++) begin
            if (req_data_i.be[i]) begin
                hi_pos = 3'(i);  // Last hit is the highest
            end
        end
    end

    // Store size and offset from the enable pattern
    always_comb begin : align_comb
        wt_size = 2'd3;
        wt_off  = '0;
        case (be_cnt)
            4'd1: begin
                wt_size = 2'd0;
                wt_off  = hi_pos;
            end
            4'd2: begin
                wt_size = 2'd1;
                wt_off  = hi_pos - 3'd1;
            end
            4'd4: begin
                wt_size = 2'd2;
                wt_off  = hi_pos - 3'd3;
            end
            default: ;  // Full double word
        endcase
    end

    assign wt_addr = (wt_size == 2'd3) ? req_i.addr
                                       : {req_i.addr[`L15A_ADDR_W-1:3], wt_off};

    // Copy the 2^size bytes at the offset over the whole double word
    always_comb begin : rep_comb
        logic [2:0] lane_mask;
        logic [2:0] src;
        lane_mask = 3'((4'd1 << wt_size) - 4'd1);
        for (int i = 0; i < `L15A_BE_W; i++) begin
            src = wt_off + (3'(i) & lane_mask);
            rep_data[8*i +: 8] = req_data_i.data[8*src +: 8];
        end
    end

    assign st_data      = is_unc_st ? rep_data : req_data_i.data;
    assign st_data_swap = {<<8{st_data}};
    assign be_swap      = {<<{req_data_i.be}};

    assign rqtype_o  = (is_wbuf_st || is_unc_st) ? l15_adapter_pkg::L15_STORE_RQ
                                                 : l15_adapter_pkg::L15_LOAD_RQ;
    assign nc_o      = ~req_i.cacheable;
    assign size_o    = is_wbuf_st ? ({1'b0, wt_size} + 3'd1) : (req_i.size + 3'd1);
    assign address_o = is_wbuf_st ? wt_addr : req_i.addr;
    assign data_o    = SWAP_ENDIAN ? st_data_swap : st_data;
    assign be_o      = SWAP_ENDIAN ? be_swap : req_data_i.be;

    always_comb begin : wbuf_be_chk
        if (is_wbuf_st) begin
            assert final (req_data_i.be != '0)
                else $error("Write-buffer store with no byte enabled");
        end
    end

endmodule

/* source/l15_resp_decoder.sv */
// ------------------------------------------------
// L1.5 return decoder
// Rebuilds the cache response and its port from
// the thread id tables
// ------------------------------------------------
`timescale 1ns/1ps
`include "l15_adapter_macros.svh"

module l15_resp_decoder #(
    parameter bit SWAP_ENDIAN = 1'b1
) (
    input  l15_adapter_pkg::l15_rtrn_t  l15_rtrn_i,
    input  logic                        resp_ready_i,
    input  logic [`L15A_MEM_ID_W-1:0]   lookup_id_i,
    input  logic [`L15A_PID_W-1:0]      lookup_pid_i,
    output logic [`L15A_TID_W-1:0]      lookup_tid_o,
    output logic                        resp_valid_o,
    output logic [`L15A_PID_W-1:0]      resp_pid_o,
    output l15_adapter_pkg::mem_resp_t  resp_o,
    output logic                        req_ack_o
);

    logic [`L15A_DATA_W-1:0] data_swap;

    assign data_swap = {<<8{l15_rtrn_i.data}};  // L1.5 is big endian

    assign lookup_tid_o = l15_rtrn_i.threadid;
    assign resp_valid_o = l15_rtrn_i.val;
    assign resp_pid_o   = lookup_pid_i;
    assign req_ack_o    = l15_rtrn_i.val & resp_ready_i;  // Hold the return under back-pressure

    assign resp_o.id    = lookup_id_i;
    assign resp_o.error = (l15_rtrn_i.returntype == l15_adapter_pkg::L15_ERR_RET);
    assign resp_o.data  = SWAP_ENDIAN ? data_swap : l15_rtrn_i.data;

endmodule

/* source/l15_thread_ctrl.sv */
// ------------------------------------------------
// L1.5 thread id control
// Header-ack/ack request handshake and the tables
// of cache id and port per thread id
// ------------------------------------------------
`timescale 1ns/1ps
`include "l15_adapter_macros.svh"

module l15_thread_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      req_valid_i,
    input  logic [`L15A_PID_W-1:0]    req_pid_i,
    input  logic [`L15A_MEM_ID_W-1:0] req_id_i,
    input  logic                      header_ack_i,
    input  logic                      ack_i,
    input  logic                      rtrn_val_i,
    input  logic [`L15A_TID_W-1:0]    rtrn_tid_i,
    input  logic                      resp_ready_i,
    output logic                      l15_val_o,
    output logic [`L15A_TID_W-1:0]    l15_tid_o,
    output logic                      req_ready_o,
    input  logic [`L15A_TID_W-1:0]    lookup_tid_i,
    output logic [`L15A_MEM_ID_W-1:0] lookup_id_o,
    output logic [`L15A_PID_W-1:0]    lookup_pid_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_HEADER_ACK,
        WAIT_ACK         // val low, fields held
    } state_e;

    state_e                    state_q, state_d;
    logic                      id_avail;
    logic                      retire;
    logic [`L15A_MEM_ID_W-1:0] id_tab [`L15A_NUM_THIDS];
    logic [`L15A_PID_W-1:0]    pid_tab [`L15A_NUM_THIDS];

    assign retire = rtrn_val_i & resp_ready_i;  // Return consumed

    thid_free_list i_free_list (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .put_i     (retire),
        .put_tid_i (rtrn_tid_i),
        .get_i     (req_ready_o),
        .avail_o   (id_avail),
        .tid_o     (l15_tid_o)
    );

    always_comb begin : fsm_comb
        state_d     = state_q;
        l15_val_o   = 1'b0;
        req_ready_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_valid_i && id_avail) begin
                    l15_val_o = 1'b1;
                    if (!header_ack_i) state_d = WAIT_HEADER_ACK;
                    else if (!ack_i) state_d = WAIT_ACK;
                    else req_ready_o = 1'b1;
                end
            end
            WAIT_HEADER_ACK: begin
                l15_val_o = 1'b1;
                if (header_ack_i) begin
                    req_ready_o = ack_i;
                    state_d     = ack_i ? IDLE : WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                if (ack_i) begin
                    req_ready_o = 1'b1;
                    state_d     = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) state_q <= IDLE;
        else state_q <= state_d;
    end

    // Tag of the accepted request, kept until its return
    always_ff @(posedge clk_i) begin
        if (req_ready_o) begin
            id_tab[l15_tid_o]  <= req_id_i;
            pid_tab[l15_tid_o] <= req_pid_i;
        end
    end

    assign lookup_id_o  = id_tab[lookup_tid_i];
    assign lookup_pid_o = pid_tab[lookup_tid_i];

    ready_on_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_ready_o |-> ack_i && id_avail);
    // Cache request held steady through the L1.5 handshake
    valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q != IDLE |-> req_valid_i && $stable(req_id_i) && $stable(req_pid_i));

endmodule

/* source/thid_free_list.sv */
// ------------------------------------------------
// L1.5 thread id free list
// Circular queue, full with every id out of reset
// ------------------------------------------------
`timescale 1ns/1ps
`include "l15_adapter_macros.svh"

module thid_free_list (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   put_i,
    input  logic [`L15A_TID_W-1:0] put_tid_i,
    input  logic                   get_i,
    output logic                   avail_o,
    output logic [`L15A_TID_W-1:0] tid_o
);

    localparam int CNT_W = $clog2(`L15A_NUM_THIDS + 1);

    logic [`L15A_TID_W-1:0] ids_q [`L15A_NUM_THIDS];
    logic [`L15A_TID_W-1:0] rd_ptr_q;
    logic [`L15A_TID_W-1:0] wr_ptr_q;  // Wraps with the id count
    logic [CNT_W-1:0]       cnt_q;
    logic                   full;

    assign full    = (cnt_q == CNT_W'(`L15A_NUM_THIDS));
    assign avail_o = (cnt_q != '0);
    assign tid_o   = ids_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `L15A_NUM_THIDS; i++) begin
                ids_q[i] <= `L15A_TID_W'(i);
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= CNT_W'(`L15A_NUM_THIDS);
        end else begin
            if (put_i) begin
                ids_q[wr_ptr_q] <= put_tid_i;
                wr_ptr_q        <= wr_ptr_q + 1'b1;
            end
            if (get_i) rd_ptr_q <= rd_ptr_q + 1'b1;
            cnt_q <= cnt_q + CNT_W'(put_i) - CNT_W'(get_i);
        end
    end

    put_not_full: assert property (@(posedge clk_i) disable iff (!rst_ni) put_i |-> !full);
    get_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni) get_i |-> avail_o);

endmodule

/* src.f */
+incdir+source
source/l15_adapter_pkg.sv
source/l15_req_encoder.sv
source/thid_free_list.sv
source/l15_thread_ctrl.sv
source/l15_resp_decoder.sv
source/hpdc_l15_adapter.sv
tests/tb_hpdc_l15_adapter.sv

/* tests/tb_hpdc_l15_adapter.sv */
// ------------------------------------------------
// HPDC to L1.5 adapter testbench
// L1.5 model with random acks and out-of-order
// returns, checked against reference functions
// ------------------------------------------------
`timescale 1ns/1ps
`include "l15_adapter_macros.svh"

module tb_hpdc_l15_adapter;

    localparam int NUM_TXN        = 200;
    localparam int MAX_TXN_CYCLES = 20;
    localparam int TIMEOUT_CYCLES = NUM_TXN * MAX_TXN_CYCLES + 1000;  // Reset and drain margin

    // Request accepted by the L1.5 model, waiting for its return
    typedef struct packed {
        logic [`L15A_TID_W-1:0]    tid;
        logic [`L15A_MEM_ID_W-1:0] id;
        logic [`L15A_PID_W-1:0]    pid;
    } pending_t;

    logic                        clk_i;
    logic                        rst_ni;
    logic                        req_valid_i;
    logic [`L15A_PID_W-1:0]      req_pid_i;
    l15_adapter_pkg::mem_req_t   req_i;
    l15_adapter_pkg::mem_wdata_t req_data_i;
    logic                        req_ready_o;
    logic                        resp_ready_i;
    logic                        resp_valid_o;
    logic [`L15A_PID_W-1:0]      resp_pid_o;
    l15_adapter_pkg::mem_resp_t  resp_o;
    l15_adapter_pkg::l15_req_t   l15_req_o;
    l15_adapter_pkg::l15_rtrn_t  l15_rtrn_i;

    integer   seed = 98503;
    int       cycle_cnt = 0;
    pending_t pending [$];

    hpdc_l15_adapter uut (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (req_valid_i),
        .req_pid_i    (req_pid_i),
        .req_i        (req_i),
        .req_data_i   (req_data_i),
        .req_ready_o  (req_ready_o),
        .resp_ready_i (resp_ready_i),
        .resp_valid_o (resp_valid_o),
        .resp_pid_o   (resp_pid_o),
        .resp_o       (resp_o),
        .l15_req_o    (l15_req_o),
        .l15_rtrn_i   (l15_rtrn_i)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "Simulation timed out");
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // L1.5 words are big endian
    function automatic logic [`L15A_DATA_W-1:0] reverse_bytes(
        input logic [`L15A_DATA_W-1:0] d
    );
        logic [`L15A_DATA_W-1:0] r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = d[8*(7-i) +: 8];
        end
        return r;
    endfunction

    function automatic l15_adapter_pkg::l15_req_t expect_request(
        input logic [`L15A_PID_W-1:0]      pid,
        input l15_adapter_pkg::mem_req_t   r,
        input l15_adapter_pkg::mem_wdata_t w
    );
        l15_adapter_pkg::l15_req_t e;
        logic [`L15A_DATA_W-1:0]   d;
        logic                      store;
        int                        cnt;
        int                        hi;
        int                        off;
        int                        nbytes;
        e       = '0;
        store   = (r.command == l15_adapter_pkg::MEM_WRITE) &&
                  (pid == `L15A_PORT_WBUF || pid == `L15A_PORT_UNC_WR);
        e.rqtype  = store ? l15_adapter_pkg::L15_STORE_RQ : l15_adapter_pkg::L15_LOAD_RQ;
        e.nc      = !r.cacheable;
        e.size    = r.size + 3'd1;
        e.address = r.addr;
        d         = w.data;
        if (store && pid == `L15A_PORT_WBUF) begin
            cnt = 0;
            hi  = 0;
            for (int i = 0; i < 8; i++) begin
                if (w.be[i]) begin
                    cnt++;
                    hi = i;
                end
            end
            case (cnt)
                1: begin
                    e.size         = 3'd1;
                    e.address[2:0] = 3'(hi);
                end
                2: begin
                    e.size         = 3'd2;
                    e.address[2:0] = 3'(hi - 1);
                end
                4: begin
                    e.size         = 3'd3;
                    e.address[2:0] = 3'(hi - 3);
                end
                default: e.size = 3'd4;  // Full double word
            endcase
        end else if (store) begin
            // Addressed bytes copied over the double word
            nbytes = 1 << r.size;
            off    = int'(r.addr[2:0]);
            for (int i = 0; i < 8; i++) begin
                d[8*i +: 8] = w.data[8*(off + i % nbytes) +: 8];
            end
        end
        e.data = reverse_bytes(d);
        for (int i = 0; i < 8; i++) begin
            e.be[i] = w.be[7-i];
        end
        return e;
    endfunction

    function automatic l15_adapter_pkg::mem_resp_t expect_response(
        input logic [`L15A_MEM_ID_W-1:0]    id,
        input l15_adapter_pkg::l15_rettype_e rt,
        input logic [`L15A_DATA_W-1:0]      rdata
    );
        l15_adapter_pkg::mem_resp_t e;
        e.id    = id;
        e.error = (rt == l15_adapter_pkg::L15_ERR_RET);
        e.data  = reverse_bytes(rdata);
        return e;
    endfunction

    task automatic make_request(output logic [`L15A_PID_W-1:0]      pid,
                                output l15_adapter_pkg::mem_req_t   r,
                                output l15_adapter_pkg::mem_wdata_t w);
        logic [15:0] mask;
        int          off;
        int          nbytes;
        pid         = `L15A_PID_W'({$random(seed)} % 4);
        r.addr      = `L15A_ADDR_W'({$random(seed), $random(seed)});
        r.size      = 3'({$random(seed)} % 4);
        r.id        = `L15A_MEM_ID_W'($random(seed));
        r.cacheable = (pid == `L15A_PORT_RD) || (pid == `L15A_PORT_WBUF);
        r.command   = (pid == `L15A_PORT_WBUF || pid == `L15A_PORT_UNC_WR) ?
                      l15_adapter_pkg::MEM_WRITE : l15_adapter_pkg::MEM_READ;
        w.data      = {$random(seed), $random(seed)};
        w.be        = '0;
        if (pid == `L15A_PORT_WBUF) begin
            case ({$random(seed)} % 4)
                0: w.be = 8'h01 << ({$random(seed)} % 8);        // Single byte
                1: w.be = 8'h03 << (2 * ({$random(seed)} % 4));  // Pair
                2: w.be = 8'h0F << (4 * ({$random(seed)} % 2));  // Word
                default: w.be = 8'hFF;
            endcase
        end else if (pid == `L15A_PORT_UNC_WR) begin
            nbytes      = 1 << r.size;
            off         = int'({$random(seed)} % 8) & ~(nbytes - 1);
            r.addr[2:0] = 3'(off);
            mask        = 16'((1 << nbytes) - 1) << off;
            w.be        = mask[7:0];
        end
    endtask

    task automatic start_request(input logic [`L15A_PID_W-1:0]      pid,
                                 input l15_adapter_pkg::mem_req_t   r,
                                 input l15_adapter_pkg::mem_wdata_t w);
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_pid_i   <= pid;
        req_i       <= r;
        req_data_i  <= w;
    endtask

    // L1.5 side of the request handshake, then field checks
    task automatic finish_request(input logic [`L15A_PID_W-1:0]      pid,
                                  input l15_adapter_pkg::mem_req_t   r,
                                  input l15_adapter_pkg::mem_wdata_t w);
        l15_adapter_pkg::l15_req_t exp;
        logic [`L15A_TID_W-1:0]    acc_tid;
        int                        hdr_dly;
        int                        ack_dly;
        do @(negedge clk_i); while (!l15_req_o.val);
        exp = expect_request(pid, r, w);
        check_value("l15_req_o.rqtype", 128'(l15_req_o.rqtype), 128'(exp.rqtype));
        check_value("l15_req_o.nc", 128'(l15_req_o.nc), 128'(exp.nc));
        check_value("l15_req_o.size", 128'(l15_req_o.size), 128'(exp.size));
        check_value("l15_req_o.address", 128'(l15_req_o.address), 128'(exp.address));
        if (exp.rqtype == l15_adapter_pkg::L15_STORE_RQ) begin
            check_value("l15_req_o.data", 128'(l15_req_o.data), 128'(exp.data));
            check_value("l15_req_o.be", 128'(l15_req_o.be), 128'(exp.be));
        end
        check_value("req_ready_o", 128'(req_ready_o), 128'(0));
        hdr_dly = int'({$random(seed)} % 4);
        ack_dly = int'({$random(seed)} % 3);
        repeat (hdr_dly) begin
            @(negedge clk_i);
            check_value("l15_req_o.val", 128'(l15_req_o.val), 128'(1));
        end
        @(posedge clk_i);
        l15_rtrn_i.header_ack <= 1'b1;
        l15_rtrn_i.ack        <= (ack_dly == 0);
        @(negedge clk_i);
        check_value("req_ready_o", 128'(req_ready_o), 128'(ack_dly == 0));
        for (int i = 1; i <= ack_dly; i++) begin
            @(posedge clk_i);
            l15_rtrn_i.header_ack <= 1'b0;
            l15_rtrn_i.ack        <= (i == ack_dly);
            @(negedge clk_i);
            check_value("l15_req_o.val", 128'(l15_req_o.val), 128'(0));  // Dropped after header_ack
            check_value("req_ready_o", 128'(req_ready_o), 128'(i == ack_dly));
        end
        acc_tid = l15_req_o.threadid;
        foreach (pending[j]) begin
            check_value("l15_req_o.threadid in use", 128'(pending[j].tid == acc_tid), 128'(0));
        end
        pending.push_back('{tid: acc_tid, id: r.id, pid: pid});
        @(posedge clk_i);
        l15_rtrn_i.header_ack <= 1'b0;
        l15_rtrn_i.ack        <= 1'b0;
        req_valid_i           <= 1'b0;
    endtask

    // Returns one outstanding request, picked at random, with optional back-pressure
    task automatic return_response();
        pending_t                      p;
        l15_adapter_pkg::mem_resp_t    exp;
        l15_adapter_pkg::l15_rettype_e rt;
        logic [`L15A_DATA_W-1:0]       rdata;
        int                            k;
        int                            stall;
        k = int'({$random(seed)} % pending.size());
        p = pending[k];
        pending.delete(k);
        rdata = {$random(seed), $random(seed)};
        if ({$random(seed)} % 8 == 0) rt = l15_adapter_pkg::L15_ERR_RET;
        else if (p.pid == `L15A_PORT_WBUF || p.pid == `L15A_PORT_UNC_WR) begin
            rt = l15_adapter_pkg::L15_ST_ACK;
        end else rt = l15_adapter_pkg::L15_LOAD_RET;
        stall = ({$random(seed)} % 3 == 0) ? 1 + int'({$random(seed)} % 3) : 0;
        exp   = expect_response(p.id, rt, rdata);
        @(posedge clk_i);
        l15_rtrn_i.val        <= 1'b1;
        l15_rtrn_i.threadid   <= p.tid;
        l15_rtrn_i.returntype <= rt;
        l15_rtrn_i.data       <= rdata;
        resp_ready_i          <= (stall == 0);
        for (int i = 0; i <= stall; i++) begin
            @(negedge clk_i);
            check_value("resp_valid_o", 128'(resp_valid_o), 128'(1));
            check_value("resp_pid_o", 128'(resp_pid_o), 128'(p.pid));
            check_value("resp_o.id", 128'(resp_o.id), 128'(exp.id));
            check_value("resp_o.error", 128'(resp_o.error), 128'(exp.error));
            check_value("resp_o.data", 128'(resp_o.data), 128'(exp.data));
            check_value("l15_req_o.req_ack", 128'(l15_req_o.req_ack), 128'(i == stall));
            if (i < stall) begin
                @(posedge clk_i);
                resp_ready_i <= (i + 1 == stall);
            end
        end
        @(posedge clk_i);
        l15_rtrn_i.val <= 1'b0;
        resp_ready_i   <= 1'b0;
    endtask

    initial begin : stimulus
        logic [`L15A_PID_W-1:0]      pid;
        l15_adapter_pkg::mem_req_t   r;
        l15_adapter_pkg::mem_wdata_t w;
        rst_ni       = 1'b0;
        req_valid_i  = 1'b0;
        req_pid_i    = '0;
        req_i        = '0;
        req_data_i   = '0;
        resp_ready_i = 1'b0;
        l15_rtrn_i   = '0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_value("l15_req_o.val", 128'(l15_req_o.val), 128'(0));
        check_value("req_ready_o", 128'(req_ready_o), 128'(0));
        check_value("resp_valid_o", 128'(resp_valid_o), 128'(0));
        for (int n = 0; n < NUM_TXN; n++) begin
            make_request(pid, r, w);
            start_request(pid, r, w);
            if (pending.size() == `L15A_NUM_THIDS) begin
                // No free thread id, so the request must stall
                repeat (3) begin
                    @(negedge clk_i);
                    check_value("l15_req_o.val", 128'(l15_req_o.val), 128'(0));
                    check_value("req_ready_o", 128'(req_ready_o), 128'(0));
                end
                return_response();
            end
            finish_request(pid, r, w);
            while (pending.size() > 0 && {$random(seed)} % 3 == 0) return_response();
        end
        while (pending.size() > 0) return_response();
        $display("TEST PASSED");
        $finish;
    end

endmodule
